// ==== build.f ====
sdram_pkg.sv
sdram_ctrl.sv
sdram_arbiter.sv
sdram_subsys_top.sv
sdram_model.sv
tb_clock_gen.sv
tb_sdram_asserts.sv
tb_sdram_subsys.sv

// ==== run.sh ====
#!/bin/sh
# build and run, exit status gives the result
verilator --binary --timing --assert -f build.f --top-module tb_sdram_subsys -o sim \
  && ./obj_dir/sim \
  || exit 1

// ==== sdram_arbiter.sv ====
module sdram_arbiter (
  input  logic                       clk,
  input  logic                       resetn,
  input  logic [1:0]                 req_valid,
  input  sdram_pkg::mem_req_t [1:0]  req,
  output logic [1:0]                 req_ready,
  output logic [31:0]                rdata,
  output logic                       ctrl_valid,
  output sdram_pkg::mem_req_t        ctrl_req,
  input  logic                       ctrl_ready,
  input  logic [31:0]                ctrl_rdata
);

  logic busy_q;       // one access owned by the controller
  logic grant_q;      // port being served
  logic last_q;       // port served last
  logic just_done_q;  // cycle right after a ready pulse

  logic [1:0] blocked;
  logic [1:0] cand;
  logic       pick;
  logic       pick_ok;

  // the port just served still shows valid for one more cycle
  always_comb begin
    blocked = 2'b00;
    if (just_done_q) begin
      blocked[last_q] = 1'b1;
    end
    cand    = req_valid & ~blocked;
    pick_ok = |cand;
    pick    = cand[~last_q] ? ~last_q : last_q;  // other port first
  end

  always_ff @(posedge clk) begin
    if (!resetn) begin
      busy_q      <= 1'b0;
      grant_q     <= 1'b0;
      last_q      <= 1'b1;  // port 0 wins the first round
      just_done_q <= 1'b0;
    end else begin
      just_done_q <= 1'b0;
      if (busy_q) begin
        if (ctrl_ready) begin
          busy_q      <= 1'b0;
          last_q      <= grant_q;
          just_done_q <= 1'b1;
        end
      end else if (pick_ok) begin
        busy_q  <= 1'b1;
        grant_q <= pick;
      end
    end
  end

  // request held steady by the port until ready, latched once
  always_ff @(posedge clk) begin
    if (!busy_q && pick_ok) begin
      ctrl_req <= req[pick];
    end
  end

  // dropped in the ready cycle so idle never sees it again
  assign ctrl_valid = busy_q & ~ctrl_ready;

  always_comb begin
    req_ready          = 2'b00;
    req_ready[grant_q] = ctrl_ready;
  end

  assign rdata = ctrl_rdata;  // only the ready port samples it

endmodule

// ==== sdram_ctrl.sv ====
module sdram_ctrl (
  input  logic                   clk,
  input  logic                   resetn,
  input  logic                   valid,
  input  sdram_pkg::mem_req_t    req,
  output logic                   ready,
  output logic [31:0]            rdata,
  output sdram_pkg::sdram_cmd_t  pins,
  output logic [31:0]            dq_out,
  output logic                   dq_oe,
  input  logic [31:0]            dq_in
);

  typedef enum logic [3:0] {
    st_reset,
    st_init_pre,
    st_init_ref0,
    st_init_ref1,
    st_init_mrs,
    st_idle,
    st_read_col,    // read with auto precharge, shared by read and rmw
    st_rd_done,
    st_wr_rd_done,
    st_wr_act,
    st_wr_col,
    st_wait
  } state_t;

  state_t state;
  state_t ret_q;                             // where st_wait goes next
  logic [sdram_pkg::wait_w-1:0] wait_cnt;
  logic done_q;                              // access finished, pulse ready on return

  logic                cke_q;
  logic [3:0]          cmd_q;
  logic [1:0]          ba_q;
  sdram_pkg::sdram_a_u a_q;
  logic [3:0]          dqm_q;

  sdram_pkg::sdram_a_u mode_a;
  sdram_pkg::sdram_a_u col_a;
  logic [31:0]         merged;
  logic                is_write;

  assign is_write = |req.wmask;

  // mode register word and column word built through the two views
  always_comb begin
    mode_a.mode_view.rsvd        = 1'b0;
    mode_a.mode_view.write_burst = 1'b1;    // no write bursts
    mode_a.mode_view.op_mode     = 2'b00;
    mode_a.mode_view.cas         = sdram_pkg::cas_latency[2:0];
    mode_a.mode_view.access_type = 1'b0;
    mode_a.mode_view.burst_len   = 3'b000;  // burst of one
    col_a.col_view.auto_pre      = 1'b1;
    col_a.col_view.gap           = 2'b00;
    col_a.col_view.col           = req.addr.col;
  end

  // new bytes where the mask is set, old word elsewhere
  always_comb begin
    for (int i = 0; i < 4; i++) begin
      merged[8*i +: 8] = req.wmask[i] ? req.wdata[8*i +: 8] : dq_in[8*i +: 8];
    end
  end

  always_comb begin
    pins.cke  = cke_q;
    pins.csn  = cmd_q[3];
    pins.rasn = cmd_q[2];
    pins.casn = cmd_q[1];
    pins.wen  = cmd_q[0];
    pins.ba   = ba_q;
    pins.a    = a_q;
    pins.dqm  = dqm_q;
  end

  always_ff @(posedge clk) begin
    if (!resetn) begin
      state  <= st_reset;
      ready  <= 1'b0;
      done_q <= 1'b0;
      cke_q  <= 1'b0;
      cmd_q  <= sdram_pkg::cmd_nop;
      dq_oe  <= 1'b0;
    end else begin
      ready <= 1'b0;
      dq_oe <= 1'b0;
      case (state)
        st_reset: begin
          a_q      <= '0;
          ba_q     <= '0;
          dqm_q    <= 4'hf;
          wait_cnt <= sdram_pkg::wait_100us;  // power-up wait
          ret_q    <= st_init_pre;
          state    <= st_wait;
        end

        st_init_pre: begin
          cke_q    <= 1'b1;
          cmd_q    <= sdram_pkg::cmd_pre;
          a_q      <= 11'h400;  // a10 high, all banks
          wait_cnt <= sdram_pkg::trp;
          ret_q    <= st_init_ref0;
          state    <= st_wait;
        end

        st_init_ref0: begin
          cmd_q    <= sdram_pkg::cmd_ref;
          a_q      <= '0;
          wait_cnt <= sdram_pkg::trc;
          ret_q    <= st_init_ref1;
          state    <= st_wait;
        end

        st_init_ref1: begin
          cmd_q    <= sdram_pkg::cmd_ref;
          a_q      <= '0;
          wait_cnt <= sdram_pkg::trc;
          ret_q    <= st_init_mrs;
          state    <= st_wait;
        end

        st_init_mrs: begin
          cmd_q    <= sdram_pkg::cmd_mrs;
          a_q      <= mode_a;
          wait_cnt <= sdram_pkg::tch;
          ret_q    <= st_idle;
          state    <= st_wait;
        end

        st_idle: begin
          dqm_q <= 4'hf;
          if (valid) begin
            cmd_q    <= sdram_pkg::cmd_act;
            a_q      <= req.addr.row;
            ba_q     <= req.addr.bank;
            wait_cnt <= sdram_pkg::trcd;
            ret_q    <= st_read_col;  // writes read the old word first
            state    <= st_wait;
          end else begin
            cmd_q    <= sdram_pkg::cmd_ref;  // refresh while nothing to do
            a_q      <= '0;
            ba_q     <= '0;
            wait_cnt <= sdram_pkg::trc;
            ret_q    <= st_idle;
            state    <= st_wait;
          end
        end

        st_read_col: begin
          cmd_q    <= sdram_pkg::cmd_read;
          dqm_q    <= 4'h0;
          a_q      <= col_a;
          ba_q     <= req.addr.bank;
          wait_cnt <= sdram_pkg::cas_latency;
          ret_q    <= is_write ? st_wr_rd_done : st_rd_done;
          state    <= st_wait;
        end

        st_rd_done: begin
          cmd_q    <= sdram_pkg::cmd_nop;
          dqm_q    <= 4'hf;
          rdata    <= dq_in;  // word arrives cas_latency after read
          a_q      <= '0;
          ba_q     <= '0;
          wait_cnt <= sdram_pkg::trp;  // auto precharge finishing
          done_q   <= 1'b1;
          ret_q    <= st_idle;
          state    <= st_wait;
        end

        st_wr_rd_done: begin
          cmd_q    <= sdram_pkg::cmd_nop;
          dqm_q    <= 4'hf;
          dq_out   <= merged;
          a_q      <= '0;
          ba_q     <= '0;
          wait_cnt <= sdram_pkg::trp;
          ret_q    <= st_wr_act;
          state    <= st_wait;
        end

        st_wr_act: begin
          cmd_q    <= sdram_pkg::cmd_act;  // row closed by the read, open again
          a_q      <= req.addr.row;
          ba_q     <= req.addr.bank;
          wait_cnt <= sdram_pkg::trcd;
          ret_q    <= st_wr_col;
          state    <= st_wait;
        end

        st_wr_col: begin
          cmd_q    <= sdram_pkg::cmd_write;
          dqm_q    <= 4'h0;  // whole merged word
          dq_oe    <= 1'b1;  // same cycle as the write command
          a_q      <= col_a;
          ba_q     <= req.addr.bank;
          wait_cnt <= sdram_pkg::trp;
          done_q   <= 1'b1;
          ret_q    <= st_idle;
          state    <= st_wait;
        end

        st_wait: begin
          cmd_q <= sdram_pkg::cmd_nop;
          a_q   <= '0;
          if (wait_cnt == 1) begin
            if (ret_q == st_idle && done_q) begin
              ready  <= 1'b1;  // one cycle, back in idle
              done_q <= 1'b0;
            end
            state <= ret_q;
          end else begin
            wait_cnt <= wait_cnt - 1'b1;
          end
        end

        default: begin
          state <= st_reset;
        end
      endcase
    end
  end

endmodule

// ==== sdram_model.sv ====
module sdram_model (
  input  logic                   clk,
  input  sdram_pkg::sdram_cmd_t  pins,
  input  logic [31:0]            dq_out,
  input  logic                   dq_oe,
  output logic [31:0]            dq_in
);

  logic [31:0]         mem [logic [20:0]];  // only touched words are stored
  logic [10:0]         open_row [0:3];
  logic [31:0]         rd_pipe;             // first cas latency stage
  logic [3:0]          cmd;
  sdram_pkg::sdram_a_u a;
  logic [20:0]         idx;

  always_comb begin
    cmd = {pins.csn, pins.rasn, pins.casn, pins.wen};
    a   = pins.a;
    idx = {pins.ba, open_row[pins.ba], a.col_view.col};
  end

  initial begin
    dq_in   = '0;
    rd_pipe = '0;
    for (int i = 0; i < 4; i++) begin
      open_row[i] = '0;
    end
  end

  always @(posedge clk) begin
    logic [31:0] word;
    dq_in <= rd_pipe;  // second stage, valid two cycles after read
    if (pins.cke) begin
      case (cmd)
        sdram_pkg::cmd_act: begin
          open_row[pins.ba] <= pins.a;
        end
        sdram_pkg::cmd_read: begin
          rd_pipe <= mem.exists(idx) ? mem[idx] : 32'h0;
        end
        sdram_pkg::cmd_write: begin
          if (dq_oe) begin
            word = mem.exists(idx) ? mem[idx] : 32'h0;
            for (int i = 0; i < 4; i++) begin
              if (!pins.dqm[i]) begin
                word[8*i +: 8] = dq_out[8*i +: 8];  // dqm low lets the byte through
              end
            end
            mem[idx] = word;
          end
        end
        default: begin
        end
      endcase
    end
  end

endmodule

// ==== sdram_pkg.sv ====
package sdram_pkg;

  localparam int clk_mhz = 64;  // controller clock in mhz
  localparam int wait_w  = 14;  // wide enough for the 100 us count

  // wait counts in clk cycles, ns * mhz / 1000 rounded up by one
  localparam logic [wait_w-1:0] wait_100us  = wait_w'(100 * clk_mhz);
  localparam logic [wait_w-1:0] trp         = wait_w'((15 * clk_mhz / 1000) + 1);  // 15 ns
  localparam logic [wait_w-1:0] trc         = wait_w'((60 * clk_mhz / 1000) + 1);  // 60 ns
  localparam logic [wait_w-1:0] trcd        = wait_w'((15 * clk_mhz / 1000) + 1);  // 15 ns
  localparam logic [wait_w-1:0] tch         = wait_w'((2 * clk_mhz / 1000) + 1);   // 2 ns
  localparam logic [wait_w-1:0] cas_latency = wait_w'(2);

  // command encodings as {csn, rasn, casn, wen}
  localparam logic [3:0] cmd_mrs   = 4'b0000;  // mode register set
  localparam logic [3:0] cmd_act   = 4'b0011;  // bank activate
  localparam logic [3:0] cmd_read  = 4'b0101;  // a10 high for auto precharge
  localparam logic [3:0] cmd_write = 4'b0100;  // a10 high for auto precharge
  localparam logic [3:0] cmd_pre   = 4'b0010;  // a10 high for all banks
  localparam logic [3:0] cmd_ref   = 4'b0001;  // auto refresh
  localparam logic [3:0] cmd_nop   = 4'b0111;

  typedef struct packed {
    logic [1:0]  bank;
    logic [10:0] row;
    logic [7:0]  col;
  } mem_addr_t;

  typedef struct packed {
    mem_addr_t   addr;
    logic [31:0] wdata;
    logic [3:0]  wmask;  // all zero means read
  } mem_req_t;

  typedef struct packed {
    logic        cke;
    logic        csn;
    logic        rasn;
    logic        casn;
    logic        wen;
    logic [1:0]  ba;
    logic [10:0] a;
    logic [3:0]  dqm;
  } sdram_cmd_t;

  // address pins as seen by the mode register
  typedef struct packed {
    logic       rsvd;         // a10
    logic       write_burst;  // 1 = single word writes
    logic [1:0] op_mode;      // only standard operation
    logic [2:0] cas;
    logic       access_type;  // 0 = sequential
    logic [2:0] burst_len;    // 000 = one word
  } sdram_mode_t;

  // address pins during read and write
  typedef struct packed {
    logic       auto_pre;  // a10
    logic [1:0] gap;
    logic [7:0] col;
  } sdram_col_t;

  typedef union packed {
    sdram_mode_t mode_view;
    sdram_col_t  col_view;
  } sdram_a_u;

endpackage

// ==== sdram_subsys_top.sv ====
module sdram_subsys_top (
  input  logic                       clk,
  input  logic                       resetn,
  input  logic [1:0]                 req_valid,
  input  sdram_pkg::mem_req_t [1:0]  req,
  output logic [1:0]                 req_ready,
  output logic [31:0]                rdata,
  output logic                       sdram_clk,
  output sdram_pkg::sdram_cmd_t      pins,
  output logic [31:0]                dq_out,
  output logic                       dq_oe,
  input  logic [31:0]                dq_in
);

  logic                ctrl_valid;
  sdram_pkg::mem_req_t ctrl_req;
  logic                ctrl_ready;
  logic [31:0]         ctrl_rdata;

  assign sdram_clk = clk;  // memory runs on the controller clock

  sdram_arbiter arb_i (
    .clk        (clk),
    .resetn     (resetn),
    .req_valid  (req_valid),
    .req        (req),
    .req_ready  (req_ready),
    .rdata      (rdata),
    .ctrl_valid (ctrl_valid),
    .ctrl_req   (ctrl_req),
    .ctrl_ready (ctrl_ready),
    .ctrl_rdata (ctrl_rdata)
  );

  sdram_ctrl ctrl_i (
    .clk    (clk),
    .resetn (resetn),
    .valid  (ctrl_valid),
    .req    (ctrl_req),
    .ready  (ctrl_ready),
    .rdata  (ctrl_rdata),
    .pins   (pins),
    .dq_out (dq_out),
    .dq_oe  (dq_oe),
    .dq_in  (dq_in)
  );

endmodule

// ==== tb_clock_gen.sv ====
module tb_clock_gen (
  output logic clk
);

  initial begin
    clk = 1'b0;
  end

  always #2 clk = ~clk;  // period of 4

endmodule

// ==== tb_sdram_asserts.sv ====
module tb_sdram_asserts (
  input logic                   clk,
  input logic                   resetn,
  input logic                   ready,
  input logic                   dq_oe,
  input sdram_pkg::sdram_cmd_t  pins
);

  // ready is a single cycle pulse
  ready_pulse: assert property (@(posedge clk) disable iff (!resetn) ready |=> !ready)
    else $error("ready high for two cycles");

  // data only driven with the write command
  oe_write: assert property (@(posedge clk) disable iff (!resetn)
    dq_oe |-> ({pins.csn, pins.rasn, pins.casn, pins.wen} == sdram_pkg::cmd_write))
    else $error("dq_oe without write command");

  cke_stays: assert property (@(posedge clk) disable iff (!resetn) pins.cke |=> pins.cke)
    else $error("cke dropped after init");

endmodule

bind sdram_ctrl tb_sdram_asserts asserts_i (
  .clk    (clk),
  .resetn (resetn),
  .ready  (ready),
  .dq_oe  (dq_oe),
  .pins   (pins)
);

// ==== tb_sdram_subsys.sv ====
module tb_sdram_subsys;

  localparam int timeout_cycles = 10000;
  localparam int random_count   = 12;

  logic                       clk;
  logic                       resetn;
  wire  [1:0]                 req_valid;
  wire  sdram_pkg::mem_req_t [1:0] req_bus;
  logic [1:0]                 req_ready;
  logic [31:0]                rdata;
  logic                       sdram_clk;
  sdram_pkg::sdram_cmd_t      pins;
  logic [31:0]                dq_out;
  logic                       dq_oe;
  logic [31:0]                dq_in;
  wire  [1:0]                 dir_bits;  // directed phase finished per port
  wire  [1:0]                 fin_bits;  // all accesses finished per port

  integer      seed = 52417;
  logic [31:0] rnd_tab [0:1][0:random_count-1];  // random stimulus per port
  logic [31:0] dat_tab [0:1][0:random_count-1];
  logic [31:0] shadow [logic [20:0]];
  int          order[$];                 // port index of each completion

  tb_clock_gen clk_i (.clk(clk));

  sdram_subsys_top dut_i (
    .clk       (clk),
    .resetn    (resetn),
    .req_valid (req_valid),
    .req       (req_bus),
    .req_ready (req_ready),
    .rdata     (rdata),
    .sdram_clk (sdram_clk),
    .pins      (pins),
    .dq_out    (dq_out),
    .dq_oe     (dq_oe),
    .dq_in     (dq_in)
  );

  sdram_model mem_i (
    .clk    (sdram_clk),
    .pins   (pins),
    .dq_out (dq_out),
    .dq_oe  (dq_oe),
    .dq_in  (dq_in)
  );

  // expected word; writes merge the enabled bytes into the shadow
  function automatic logic [31:0] ref_access(input sdram_pkg::mem_req_t r);
    logic [31:0] word;
    word = shadow.exists(r.addr) ? shadow[r.addr] : 32'h0;
    for (int i = 0; i < 4; i++) begin
      if (r.wmask[i]) begin
        word[8*i +: 8] = r.wdata[8*i +: 8];
      end
    end
    if (r.wmask != 4'h0) begin
      shadow[r.addr] = word;
    end
    return word;
  endfunction

  task automatic check_eq(input logic [31:0] got, input logic [31:0] exp, input string msg);
    if (got !== exp) begin
      $display("mismatch at %0t: %s, got %h expected %h", $time, msg, got, exp);
      $display("*** FAILED ***");
      $fatal(1);
    end
  endtask

  task automatic timeout_fail(input string what);
    $display("timeout at %0t: %s did not happen within %0d cycles", $time, what,
             timeout_cycles);
    $display("*** FAILED ***");
    $fatal(1);
  endtask

  for (genvar g = 0; g < 2; g++) begin : port_g
    logic                v;
    sdram_pkg::mem_req_t r;
    logic                dir_ok;
    logic                fin;

    assign req_valid[g] = v;
    assign req_bus[g]   = r;
    assign dir_bits[g]  = dir_ok;
    assign fin_bits[g]  = fin;

    task automatic access(input sdram_pkg::mem_addr_t a, input logic [31:0] d,
                          input logic [3:0] m);
      int n;
      n = 0;
      @(posedge clk);
      v <= 1'b1;  // stays up between back to back requests
      r <= '{addr: a, wdata: d, wmask: m};
      do begin
        @(negedge clk);
        n++;
      end while (!req_ready[g] && n < timeout_cycles);
      if (!req_ready[g]) begin
        timeout_fail($sformatf("ready on port %0d", g));
      end
    endtask

    task automatic drop_valid();
      @(posedge clk);
      v <= 1'b0;  // dropped on the edge after the last ready
    endtask

    initial begin
      sdram_pkg::mem_addr_t base;
      sdram_pkg::mem_addr_t ad;
      logic [31:0] rnd;
      logic [31:0] dat;
      int n;
      v      = 1'b0;
      r      = '0;
      dir_ok = 1'b0;
      fin    = 1'b0;
      n      = 0;
      while (resetn !== 1'b1 && n < timeout_cycles) begin
        @(negedge clk);
        n++;
      end
      if (resetn !== 1'b1) begin
        timeout_fail("release of reset");
      end
      if (g == 0) begin
        base = '{bank: 2'd0, row: 11'h123, col: 8'h45};
        access(base, 32'h0, 4'h0);                 // cold read through init
        access(base, 32'hdeadbeef, 4'hf);
        access(base, 32'h0, 4'h0);
        access(base, 32'h11223344, 4'hf);
        access(base, 32'haabbccdd, 4'b0010);       // byte merges via rmw
        access(base, 32'h55667788, 4'b1001);
        access(base, 32'h0, 4'h0);
        ad = base;
        ad.bank = 2'd1;                            // bank only differs
        access(ad, 32'hb0b0b0b0, 4'hf);
        ad = base;
        ad.row = 11'h124;                          // row only differs
        access(ad, 32'hc1c1c1c1, 4'hf);
        access(base, 32'h0, 4'h0);
        ad.bank = 2'd0;
        access(ad, 32'h0, 4'h0);
        ad.bank = 2'd1;
        ad.row  = 11'h123;
        access(ad, 32'h0, 4'h0);
      end
      drop_valid();
      dir_ok = 1'b1;
      n = 0;
      while (dir_bits != 2'b11 && n < timeout_cycles) begin
        @(negedge clk);
        n++;
      end
      if (dir_bits != 2'b11) begin
        timeout_fail("start of random phase");
      end
      for (int k = 0; k < random_count; k++) begin
        rnd = rnd_tab[g][k];
        dat = dat_tab[g][k];
        ad.bank = 2'(g);                          // disjoint range per port
        ad.row  = {10'h0, rnd[8]};
        ad.col  = {6'h0, rnd[5:4]};
        access(ad, dat, rnd[12] ? rnd[3:0] : 4'h0);  // about half are reads
      end
      drop_valid();
      fin = 1'b1;
    end
  end

  // compare at every ready pulse, mid cycle
  always @(negedge clk) begin
    logic [31:0] exp;
    if (resetn) begin
      for (int p = 0; p < 2; p++) begin
        if (req_ready[p]) begin
          exp = ref_access(req_bus[p]);
          if (req_bus[p].wmask == 4'h0) begin
            check_eq(rdata, exp, $sformatf("read data port %0d addr %h", p, req_bus[p].addr));
          end
          order.push_back(p);
        end
      end
    end
  end

  initial begin
    int n;
    int start;
    for (int p = 0; p < 2; p++) begin
      for (int k = 0; k < random_count; k++) begin
        rnd_tab[p][k] = $random(seed);
        dat_tab[p][k] = $random(seed);
      end
    end
    resetn = 1'b0;
    repeat (3) @(posedge clk);
    resetn <= 1'b1;
    n = 0;
    while (dir_bits != 2'b11 && n < 4 * timeout_cycles) begin
      @(negedge clk);
      n++;
    end
    if (dir_bits != 2'b11) begin
      timeout_fail("directed phase");
    end
    start = order.size();
    n = 0;
    while (fin_bits != 2'b11 && n < 4 * timeout_cycles) begin
      @(negedge clk);
      n++;
    end
    if (fin_bits != 2'b11) begin
      timeout_fail("random phase");
    end
    check_eq(32'(order.size() - start), 32'(2 * random_count), "completion count");
    for (int k = start + 1; k < order.size(); k++) begin
      check_eq({31'h0, order[k] != order[k-1]}, 32'h1, "ports alternate");
    end
    $display("*** PASSED ***");
    $finish;
  end

endmodule
